// File: Makefile
SRCS := $(wildcard include/*.svh source/*.sv tb/*.sv)

.PHONY: run clean

run: obj_dir/Vcsa_tb
	@out="$$(./obj_dir/Vcsa_tb)"; echo "$$out"; echo "$$out" | grep -qx 'Done: no errors'

obj_dir/Vcsa_tb: $(SRCS) vlog.f
	verilator --binary --assert --timescale 1ns/100ps -Wno-fatal \
		-f vlog.f --top-module csa_tb -Mdir obj_dir -o Vcsa_tb

clean:
	rm -rf obj_dir

// File: include/csa_config.svh
`ifndef CSA_CONFIG_SVH
`define CSA_CONFIG_SVH

// ******************************
// datapath and register window
// ******************************

`define CSA_DATA_WIDTH 32
`define CSA_ADDR_BITS 5

// ******************************
// engine array
// ******************************

// 2 to 8 engines.
`define CSA_UNIT_NUM 4
// power of two.
`define CSA_JOB_FIFO_DEPTH 8

`endif

// File: source/csa_job_dispatcher.sv
`default_nettype none

`include "csa_config.svh"

module csa_job_dispatcher (
	input wire axi_mm_clk,
	input wire rst_n,
	input wire job_valid_i,
	input wire csa_pkg::job_t job_i,
	input wire [`CSA_UNIT_NUM-1:0] unit_idle_i,
	output logic [`CSA_UNIT_NUM-1:0] start_o,
	output csa_pkg::job_t job_o,
	output logic dispatch_valid_o,
	output csa_pkg::unit_tag_t dispatch_unit_o,
	output logic fifo_empty_o,
	output logic fifo_full_o
);

	localparam int PTR_W = $clog2(`CSA_JOB_FIFO_DEPTH);
	localparam csa_pkg::unit_tag_t LAST_UNIT = csa_pkg::unit_tag_t'(`CSA_UNIT_NUM - 1);

	csa_pkg::job_t fifo_mem [`CSA_JOB_FIFO_DEPTH];
	logic [PTR_W:0] wr_ptr; // extra bit tells full from empty.
	logic [PTR_W:0] rd_ptr;
	csa_pkg::unit_tag_t scan_ptr;
	logic push;
	logic pop;

	// ******************************
	// job FIFO
	// ******************************

	assign fifo_empty_o = (wr_ptr == rd_ptr);
	assign fifo_full_o = (wr_ptr[PTR_W] != rd_ptr[PTR_W])
		&& (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

	assign push = job_valid_i && !fifo_full_o; // strobe dropped when full.
	assign pop = unit_idle_i[scan_ptr] && !fifo_empty_o;

	always_ff @(posedge axi_mm_clk) begin
		if (push) begin
			fifo_mem[wr_ptr[PTR_W-1:0]] <= job_i;
		end
	end

	// ******************************
	// round-robin assignment
	// ******************************

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			scan_ptr <= '0;
			start_o <= '0;
			dispatch_valid_o <= 1'b0;
			dispatch_unit_o <= '0;
		end else begin
			start_o <= '0;
			dispatch_valid_o <= 1'b0;
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
				start_o[scan_ptr] <= 1'b1;
				dispatch_valid_o <= 1'b1;
				dispatch_unit_o <= scan_ptr;
			end
			// pointer moves on every cycle, so a started engine is not picked twice.
			if (scan_ptr == LAST_UNIT) begin
				scan_ptr <= '0;
			end else begin
				scan_ptr <= scan_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge axi_mm_clk) begin
		if (pop) begin
			job_o <= fifo_mem[rd_ptr[PTR_W-1:0]]; // shared by all engines.
		end
	end

endmodule

`default_nettype wire

// File: source/csa_pkg.sv
`default_nettype none

`include "csa_config.svh"

package csa_pkg;

	// word 0 is the block, word 4 the round start.
	typedef struct packed {
		logic [`CSA_DATA_WIDTH-1:0] round_start;
		logic [`CSA_DATA_WIDTH-1:0] rounds;
		logic [2*`CSA_DATA_WIDTH-1:0] key;
		logic [`CSA_DATA_WIDTH-1:0] block;
	} job_t;

	// job in words 0 to 4, state in words 5 and 6.
	typedef struct packed {
		logic [2*`CSA_DATA_WIDTH-1:0] state;
		job_t job;
	} result_t;

	typedef logic [$clog2(`CSA_UNIT_NUM)-1:0] unit_tag_t;

	typedef enum logic [`CSA_ADDR_BITS-1:0] {
		ADDR_CHANNEL = 5'd0,
		ADDR_IN_VALID = 5'd1,
		ADDR_IN_DATA_0 = 5'd2,
		ADDR_IN_DATA_1 = 5'd3,
		ADDR_IN_DATA_2 = 5'd4,
		ADDR_IN_DATA_3 = 5'd5,
		ADDR_IN_DATA_4 = 5'd6,
		ADDR_OUT_VALID = 5'd7,
		ADDR_OUT_DATA_0 = 5'd8,
		ADDR_OUT_DATA_1 = 5'd9,
		ADDR_OUT_DATA_2 = 5'd10,
		ADDR_OUT_DATA_3 = 5'd11,
		ADDR_OUT_DATA_4 = 5'd12,
		ADDR_OUT_DATA_5 = 5'd13,
		ADDR_OUT_DATA_6 = 5'd14,
		ADDR_IDLE = 5'd15,
		ADDR_READY = 5'd16,
		ADDR_RESET = 5'd17
	} reg_addr_e;

endpackage

`default_nettype wire

// File: source/csa_regs.sv
`default_nettype none

`include "csa_config.svh"

module csa_regs (
	input wire axi_mm_clk,
	input wire rst_n,
	input wire wen_i,
	input wire [`CSA_ADDR_BITS-1:0] waddr_i,
	input wire [`CSA_DATA_WIDTH-1:0] wdata_i,
	input wire ren_i,
	input wire [`CSA_ADDR_BITS-1:0] raddr_i,
	output logic [`CSA_DATA_WIDTH-1:0] rdata_o,
	input wire dispatch_valid_i,
	input wire csa_pkg::unit_tag_t dispatch_unit_i,
	input wire csa_pkg::job_t dispatch_job_i,
	input wire result_valid_i,
	input wire csa_pkg::unit_tag_t result_unit_i,
	input wire csa_pkg::result_t result_i,
	input wire units_idle_i,
	input wire fifo_empty_i,
	input wire fifo_full_i,
	output logic core_rst_n_o
);

	localparam int DW = `CSA_DATA_WIDTH;

	typedef logic [DW-1:0] word_t;

	csa_pkg::unit_tag_t channel;
	logic chan_wr;
	logic soft_rst_q;
	logic soft_rst_q1;
	logic in_valid;
	logic out_valid;
	csa_pkg::job_t in_mirror;
	csa_pkg::result_t out_mirror;
	logic dev_idle;
	logic dev_ready;

	// ******************************
	// channel select and soft reset
	// ******************************

	assign chan_wr = wen_i && (waddr_i == csa_pkg::ADDR_CHANNEL) && (wdata_i < `CSA_UNIT_NUM);

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			channel <= '0;
			soft_rst_q <= 1'b1;
			soft_rst_q1 <= 1'b1;
		end else begin
			soft_rst_q <= !(wen_i && (waddr_i == csa_pkg::ADDR_RESET));
			soft_rst_q1 <= soft_rst_q; // stretch to two cycles.
			if (chan_wr) begin
				channel <= csa_pkg::unit_tag_t'(wdata_i);
			end
		end
	end

	assign core_rst_n_o = rst_n && soft_rst_q && soft_rst_q1;

	// ******************************
	// per-channel mirrors
	// ******************************

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			in_valid <= 1'b0;
			out_valid <= 1'b0;
		end else if (chan_wr) begin
			in_valid <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			if (dispatch_valid_i && dispatch_unit_i == channel) begin
				in_valid <= 1'b1;
			end
			if (result_valid_i && result_unit_i == channel) begin
				out_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge axi_mm_clk) begin
		if (!chan_wr && dispatch_valid_i && dispatch_unit_i == channel) begin
			in_mirror <= dispatch_job_i;
		end
		if (!chan_wr && result_valid_i && result_unit_i == channel) begin
			out_mirror <= result_i;
		end
	end

	assign dev_idle = fifo_empty_i && units_idle_i;
	assign dev_ready = !fifo_full_i;

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			rdata_o <= '0;
		end else if (ren_i) begin
			case (raddr_i)
				csa_pkg::ADDR_CHANNEL: rdata_o <= word_t'(channel);
				csa_pkg::ADDR_IN_VALID: rdata_o <= word_t'(in_valid);
				csa_pkg::ADDR_IN_DATA_0: rdata_o <= in_mirror[0*DW +: DW];
				csa_pkg::ADDR_IN_DATA_1: rdata_o <= in_mirror[1*DW +: DW];
				csa_pkg::ADDR_IN_DATA_2: rdata_o <= in_mirror[2*DW +: DW];
				csa_pkg::ADDR_IN_DATA_3: rdata_o <= in_mirror[3*DW +: DW];
				csa_pkg::ADDR_IN_DATA_4: rdata_o <= in_mirror[4*DW +: DW];
				csa_pkg::ADDR_OUT_VALID: rdata_o <= word_t'(out_valid);
				csa_pkg::ADDR_OUT_DATA_0: rdata_o <= out_mirror[0*DW +: DW];
				csa_pkg::ADDR_OUT_DATA_1: rdata_o <= out_mirror[1*DW +: DW];
				csa_pkg::ADDR_OUT_DATA_2: rdata_o <= out_mirror[2*DW +: DW];
				csa_pkg::ADDR_OUT_DATA_3: rdata_o <= out_mirror[3*DW +: DW];
				csa_pkg::ADDR_OUT_DATA_4: rdata_o <= out_mirror[4*DW +: DW];
				csa_pkg::ADDR_OUT_DATA_5: rdata_o <= out_mirror[5*DW +: DW];
				csa_pkg::ADDR_OUT_DATA_6: rdata_o <= out_mirror[6*DW +: DW];
				csa_pkg::ADDR_IDLE: rdata_o <= word_t'(dev_idle);
				csa_pkg::ADDR_READY: rdata_o <= word_t'(dev_ready);
				default: begin
					rdata_o <= {16'hE000, {(16 - `CSA_ADDR_BITS){1'b0}}, raddr_i}; // fault pattern.
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/csa_result_collector.sv
`default_nettype none

`include "csa_config.svh"

module csa_result_collector (
	input wire axi_mm_clk,
	input wire rst_n,
	input wire [`CSA_UNIT_NUM-1:0] unit_done_i,
	input wire csa_pkg::result_t unit_result_i [`CSA_UNIT_NUM],
	output logic [`CSA_UNIT_NUM-1:0] take_o,
	output logic result_valid_o,
	output csa_pkg::result_t result_o,
	output csa_pkg::unit_tag_t result_unit_o
);

	localparam csa_pkg::unit_tag_t LAST_UNIT = csa_pkg::unit_tag_t'(`CSA_UNIT_NUM - 1);

	csa_pkg::unit_tag_t scan_ptr;
	csa_pkg::unit_tag_t take_unit;
	logic take_active;

	assign take_active = |take_o;

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			scan_ptr <= '0;
			take_unit <= '0;
			take_o <= '0;
			result_valid_o <= 1'b0;
			result_unit_o <= '0;
		end else begin
			take_o <= '0;
			result_valid_o <= take_active; // one cycle behind take.
			if (take_active) begin
				result_unit_o <= take_unit;
			end
			if (unit_done_i[scan_ptr]) begin
				take_o[scan_ptr] <= 1'b1;
				take_unit <= scan_ptr;
			end
			if (scan_ptr == LAST_UNIT) begin
				scan_ptr <= '0;
			end else begin
				scan_ptr <= scan_ptr + 1'b1;
			end
		end
	end

	// the taken engine still holds its result during the take cycle.
	always_ff @(posedge axi_mm_clk) begin
		if (take_active) begin
			result_o <= unit_result_i[take_unit];
		end
	end

endmodule

`default_nettype wire

// File: source/csa_round_unit.sv
`default_nettype none

`include "csa_config.svh"

module csa_round_unit (
	input wire axi_mm_clk,
	input wire rst_n,
	input wire start_i,
	input wire csa_pkg::job_t job_i,
	input wire take_i,
	output logic idle_o,
	output logic done_o,
	output csa_pkg::result_t result_o
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_BUSY,
		ST_DONE
	} unit_state_e;

	unit_state_e state;
	csa_pkg::job_t job_q;
	logic [2*`CSA_DATA_WIDTH-1:0] data_q;
	logic [`CSA_DATA_WIDTH-1:0] round_cnt;
	logic [2*`CSA_DATA_WIDTH-1:0] mixed;
	logic [2*`CSA_DATA_WIDTH-1:0] round_next;

	// rotl3(state ^ key) + round_start + index, mod 2^64.
	assign mixed = data_q ^ job_q.key;
	assign round_next = {mixed[2*`CSA_DATA_WIDTH-4:0], mixed[2*`CSA_DATA_WIDTH-1 -: 3]}
		+ (2*`CSA_DATA_WIDTH)'(job_q.round_start)
		+ (2*`CSA_DATA_WIDTH)'(round_cnt);

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			round_cnt <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (start_i) begin
						round_cnt <= '0;
						state <= (job_i.rounds == '0) ? ST_DONE : ST_BUSY; // zero rounds skips busy.
					end
				end
				ST_BUSY: begin
					round_cnt <= round_cnt + 1'b1;
					if (round_cnt == job_q.rounds - 1'b1) begin
						state <= ST_DONE;
					end
				end
				ST_DONE: begin
					if (take_i) begin
						state <= ST_IDLE; // collector has the result.
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge axi_mm_clk) begin
		if (state == ST_IDLE && start_i) begin
			job_q <= job_i;
			data_q <= (2*`CSA_DATA_WIDTH)'(job_i.block); // block in the low word.
		end else if (state == ST_BUSY) begin
			data_q <= round_next;
		end
	end

	assign idle_o = (state == ST_IDLE);
	assign done_o = (state == ST_DONE);
	assign result_o = {data_q, job_q};

endmodule

`default_nettype wire

// File: source/csa_top.sv
`default_nettype none

`include "csa_config.svh"

module csa_top (
	input wire axi_mm_clk,
	input wire rst_n,
	input wire wen_i,
	input wire [`CSA_ADDR_BITS-1:0] waddr_i,
	input wire [`CSA_DATA_WIDTH-1:0] wdata_i,
	input wire ren_i,
	input wire [`CSA_ADDR_BITS-1:0] raddr_i,
	output wire [`CSA_DATA_WIDTH-1:0] rdata_o,
	input wire job_valid_i,
	input wire csa_pkg::job_t job_i,
	output wire result_valid_o,
	output wire csa_pkg::result_t result_o,
	output wire csa_pkg::unit_tag_t result_unit_o
);

	logic core_rst_n;
	logic [`CSA_UNIT_NUM-1:0] unit_start;
	logic [`CSA_UNIT_NUM-1:0] unit_idle;
	logic [`CSA_UNIT_NUM-1:0] unit_done;
	logic [`CSA_UNIT_NUM-1:0] unit_take;
	csa_pkg::result_t unit_result [`CSA_UNIT_NUM];
	csa_pkg::job_t start_job;
	logic dispatch_valid;
	csa_pkg::unit_tag_t dispatch_unit;
	logic fifo_empty;
	logic fifo_full;

	csa_regs u_regs (
		.axi_mm_clk(axi_mm_clk),
		.rst_n(rst_n),
		.wen_i(wen_i),
		.waddr_i(waddr_i),
		.wdata_i(wdata_i),
		.ren_i(ren_i),
		.raddr_i(raddr_i),
		.rdata_o(rdata_o),
		.dispatch_valid_i(dispatch_valid),
		.dispatch_unit_i(dispatch_unit),
		.dispatch_job_i(start_job),
		.result_valid_i(result_valid_o),
		.result_unit_i(result_unit_o),
		.result_i(result_o),
		.units_idle_i(&unit_idle), // all engines idle.
		.fifo_empty_i(fifo_empty),
		.fifo_full_i(fifo_full),
		.core_rst_n_o(core_rst_n)
	);

	csa_job_dispatcher u_dispatcher (
		.axi_mm_clk(axi_mm_clk),
		.rst_n(core_rst_n),
		.job_valid_i(job_valid_i),
		.job_i(job_i),
		.unit_idle_i(unit_idle),
		.start_o(unit_start),
		.job_o(start_job),
		.dispatch_valid_o(dispatch_valid),
		.dispatch_unit_o(dispatch_unit),
		.fifo_empty_o(fifo_empty),
		.fifo_full_o(fifo_full)
	);

	for (genvar i = 0; i < `CSA_UNIT_NUM; i++) begin : g_unit
		csa_round_unit u_unit (
			.axi_mm_clk(axi_mm_clk),
			.rst_n(core_rst_n),
			.start_i(unit_start[i]),
			.job_i(start_job),
			.take_i(unit_take[i]),
			.idle_o(unit_idle[i]),
			.done_o(unit_done[i]),
			.result_o(unit_result[i])
		);
	end

	csa_result_collector u_collector (
		.axi_mm_clk(axi_mm_clk),
		.rst_n(core_rst_n),
		.unit_done_i(unit_done),
		.unit_result_i(unit_result),
		.take_o(unit_take),
		.result_valid_o(result_valid_o),
		.result_o(result_o),
		.result_unit_o(result_unit_o)
	);

endmodule

`default_nettype wire

// File: tb/csa_tb.sv
`default_nettype none

`include "csa_config.svh"

module csa_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int UNITS = `CSA_UNIT_NUM;
	localparam int NUM_JOBS = 160;
	localparam int MIRROR_TRIES = 8;
	localparam int RESET_JOBS = 6;
	localparam int RECOVER_JOBS = 16;
	localparam int MAX_JOBS = NUM_JOBS + UNITS * MIRROR_TRIES + RESET_JOBS + RECOVER_JOBS;
	localparam int TIMEOUT_CYCLES = MAX_JOBS * 20 + 1000; // margin covers register traffic.
	localparam int DRAIN_LIMIT = 400;

	typedef logic [`CSA_ADDR_BITS-1:0] addr_t;
	typedef logic [`CSA_DATA_WIDTH-1:0] word_t;

	logic axi_mm_clk;
	logic rst_n;
	logic wen;
	addr_t waddr;
	word_t wdata;
	logic ren;
	addr_t raddr;
	word_t rdata;
	logic job_valid;
	csa_pkg::job_t job_in;
	logic res_valid;
	csa_pkg::result_t res;
	csa_pkg::unit_tag_t res_unit;

	logic [31:0] rng_state = 32'h8365;
	csa_pkg::job_t pending_jobs [$];
	logic [63:0] pending_states [$];
	int unsigned unit_hits [UNITS];
	csa_pkg::result_t last_result [UNITS];
	int value_errs;
	int other_errs;
	int cycle_count;

	csa_top dut_i (
		.axi_mm_clk(axi_mm_clk),
		.rst_n(rst_n),
		.wen_i(wen),
		.waddr_i(waddr),
		.wdata_i(wdata),
		.ren_i(ren),
		.raddr_i(raddr),
		.rdata_o(rdata),
		.job_valid_i(job_valid),
		.job_i(job_in),
		.result_valid_o(res_valid),
		.result_o(res),
		.result_unit_o(res_unit)
	);

	initial begin
		axi_mm_clk = 1'b0;
		forever #2 axi_mm_clk = ~axi_mm_clk;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge axi_mm_clk);
			cycle_count++;
		end
		$display("timeout after %0d cycles, the tests did not finish", cycle_count);
		$display("Done: errors found");
		$finish;
	end

	// ******************************
	// model and scoreboard
	// ******************************

	function automatic logic [31:0] next_random();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state;
	endfunction

	function automatic csa_pkg::job_t random_job();
		csa_pkg::job_t j;
		j.block = next_random();
		j.key = {next_random(), next_random()};
		j.rounds = (next_random() >> 16) & 32'd15; // 0 to 15 rounds.
		j.round_start = next_random();
		return j;
	endfunction

	function automatic logic [63:0] model_state(input csa_pkg::job_t j);
		logic [63:0] st;
		logic [63:0] x;
		st = {32'd0, j.block};
		for (int unsigned i = 0; i < j.rounds; i++) begin
			x = st ^ j.key;
			st = {x[60:0], x[63:61]} + {32'd0, j.round_start} + 64'(i);
		end
		return st;
	endfunction

	always @(negedge axi_mm_clk) begin : monitor_results
		int idx;
		if (res_valid) begin
			idx = -1;
			for (int k = 0; k < pending_jobs.size(); k++) begin
				if (idx < 0 && pending_jobs[k] == res.job) begin
					idx = k;
				end
			end
			assert (idx >= 0) else begin
				$display("result strobe from unit %0d belongs to no pending job", res_unit);
				other_errs++;
			end
			if (idx >= 0) begin
				assert (res.state === pending_states[idx]) else begin
					$display("Fail result_o.state: got %h, expected %h",
						res.state, pending_states[idx]);
					value_errs++;
				end
				last_result[res_unit].job = pending_jobs[idx];
				last_result[res_unit].state = pending_states[idx];
				pending_jobs.delete(idx);
				pending_states.delete(idx);
			end
			unit_hits[res_unit]++;
		end
	end

	// ******************************
	// bus tasks
	// ******************************

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge axi_mm_clk);
	endtask

	task automatic send_job(input csa_pkg::job_t j);
		@(posedge axi_mm_clk);
		job_valid <= 1'b1;
		job_in <= j;
		pending_jobs.push_back(j);
		pending_states.push_back(model_state(j));
		@(posedge axi_mm_clk);
		job_valid <= 1'b0;
	endtask

	task automatic write_reg(input addr_t addr, input word_t data);
		@(posedge axi_mm_clk);
		wen <= 1'b1;
		waddr <= addr;
		wdata <= data;
		@(posedge axi_mm_clk);
		wen <= 1'b0;
	endtask

	task automatic check_reg(input string name, input addr_t addr, input word_t exp);
		word_t data;
		@(posedge axi_mm_clk);
		ren <= 1'b1;
		raddr <= addr;
		@(posedge axi_mm_clk);
		ren <= 1'b0;
		@(negedge axi_mm_clk);
		data = rdata; // one cycle after the read strobe.
		assert (data === exp) else begin
			$display("Fail rdata_o (%s at %0d): got %h, expected %h", name, addr, data, exp);
			value_errs++;
		end
	endtask

	task automatic drain();
		int unsigned waited;
		waited = 0;
		while (pending_jobs.size() != 0 && waited < DRAIN_LIMIT) begin
			@(posedge axi_mm_clk);
			waited++;
		end
		wait_cycles(8);
		assert (pending_jobs.size() == 0) else begin
			$display("%0d jobs still pending after draining", pending_jobs.size());
			other_errs++;
		end
	endtask

	task automatic check_mirror(input int ch);
		int unsigned hits_before;
		int tries;
		logic [$bits(csa_pkg::result_t)-1:0] flat;
		write_reg(csa_pkg::ADDR_CHANNEL, word_t'(ch));
		check_reg("channel", csa_pkg::ADDR_CHANNEL, word_t'(ch));
		check_reg("in valid", csa_pkg::ADDR_IN_VALID, 32'd0);
		check_reg("out valid", csa_pkg::ADDR_OUT_VALID, 32'd0);
		hits_before = unit_hits[ch];
		tries = 0;
		while (unit_hits[ch] == hits_before && tries < MIRROR_TRIES) begin
			send_job(random_job());
			wait_cycles(9); // odd spacing walks the dispatcher over all engines.
			tries++;
		end
		drain();
		assert (unit_hits[ch] != hits_before) else begin
			$display("no result came from channel %0d", ch);
			other_errs++;
		end
		check_reg("in valid", csa_pkg::ADDR_IN_VALID, 32'd1);
		check_reg("out valid", csa_pkg::ADDR_OUT_VALID, 32'd1);
		flat = last_result[ch];
		for (int k = 0; k < 5; k++) begin
			check_reg("in data", addr_t'(csa_pkg::ADDR_IN_DATA_0 + k), flat[32*k +: 32]);
		end
		for (int k = 0; k < 7; k++) begin
			check_reg("out data", addr_t'(csa_pkg::ADDR_OUT_DATA_0 + k), flat[32*k +: 32]);
		end
	endtask

	task automatic check_status();
		check_reg("idle", csa_pkg::ADDR_IDLE, 32'd1);
		check_reg("ready", csa_pkg::ADDR_READY, 32'd1);
		for (int a = csa_pkg::ADDR_RESET + 1; a < 2**`CSA_ADDR_BITS; a++) begin
			check_reg("unmapped", addr_t'(a), 32'hE000_0000 | word_t'(a));
		end
	endtask

	task automatic soft_reset_check();
		csa_pkg::job_t j;
		int unsigned discarded;
		for (int i = 0; i < RESET_JOBS; i++) begin
			j = random_job();
			j.rounds = 32'd15; // long jobs are still running at the reset.
			send_job(j);
		end
		write_reg(csa_pkg::ADDR_RESET, 32'd1);
		wait_cycles(4);
		discarded = pending_jobs.size();
		assert (discarded > 0) else begin
			$display("no jobs were in flight when the soft reset hit");
			other_errs++;
		end
		pending_jobs.delete();
		pending_states.delete();
		wait_cycles(60); // any strobe now is a discarded job.
		check_reg("idle", csa_pkg::ADDR_IDLE, 32'd1);
		for (int i = 0; i < RECOVER_JOBS; i++) begin
			send_job(random_job());
			wait_cycles(6);
		end
		drain();
	endtask

	// ******************************
	// test sequence
	// ******************************

	initial begin
		rst_n = 1'b0;
		wen = 1'b0;
		waddr = '0;
		wdata = '0;
		ren = 1'b0;
		raddr = '0;
		job_valid = 1'b0;
		job_in = '0;
		value_errs = 0;
		other_errs = 0;
		for (int u = 0; u < UNITS; u++) begin
			unit_hits[u] = 0;
		end
		repeat (2) @(posedge axi_mm_clk);
		rst_n <= 1'b1;
		wait_cycles(4);

		check_status();
		for (int i = 0; i < NUM_JOBS; i++) begin
			send_job(random_job());
			wait_cycles(6); // one job every 8 cycles.
		end
		drain();

		for (int ch = 0; ch < UNITS; ch++) begin
			check_mirror(ch);
		end

		write_reg(csa_pkg::ADDR_CHANNEL, 32'd2);
		write_reg(csa_pkg::ADDR_CHANNEL, word_t'(UNITS));
		write_reg(csa_pkg::ADDR_CHANNEL, 32'hFFFF_FFFF);
		check_reg("channel", csa_pkg::ADDR_CHANNEL, 32'd2);

		check_status();
		soft_reset_check();

		$display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
		if (value_errs + other_errs == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+include
source/csa_pkg.sv
source/csa_round_unit.sv
source/csa_job_dispatcher.sv
source/csa_result_collector.sv
source/csa_regs.sv
source/csa_top.sv
tb/csa_tb.sv
